/* include/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Datapath widths
`define LSU_XLEN        32
`define LSU_OFFSET_W    12

// Hardware threads
`define LSU_NUM_THREADS 2
`define LSU_TID_W       1

// Memory map, each window aligned to its own size
`define LSU_DCCM_BASE   32'hF004_0000
`define LSU_DCCM_SIZE   32'h0001_0000   // 64 KiB
`define LSU_PIC_BASE    32'hF00C_0000
`define LSU_PIC_SIZE    32'h0000_8000   // 32 KiB

`endif

/* hdl/lsu_pkg.sv */
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } lsu_size_e;

   typedef enum logic [3:0] {
      MSC_NONE         = 4'h0,
      MSC_MISALIGN     = 4'h1,
      MSC_REGION_CROSS = 4'h2,
      MSC_PIC_SIZE     = 4'h3
   } lsu_mscause_e;

   // Decoded load/store packet
   typedef struct packed {
      logic                  valid;
      logic [`LSU_TID_W-1:0] tid;
      logic                  load;
      logic                  store;
      logic                  unsign;     // Zero extend on load
      lsu_size_e             size;
      logic                  atomic;
      logic                  lr;
      logic                  sc;
   } lsu_pkt_t;

   // One hot memory region
   typedef struct packed {
      logic in_dccm;
      logic in_pic;
      logic external;
   } lsu_region_t;

   typedef struct packed {
      logic                 exc_valid;
      logic                 inst_type;   // 1 for store
      logic                 exc_type;    // 1 access fault, 0 misaligned
      lsu_mscause_e         mscause;
      logic [`LSU_XLEN-1:0] addr;
   } lsu_error_pkt_t;

   // One LR reservation station
   typedef struct packed {
      logic                 vld;
      logic [`LSU_XLEN-1:2] addr;        // Word address
   } lsu_resv_t;

endpackage

`default_nettype wire

/* hdl/lsu_addr_gen.sv */
`default_nettype none

`include "lsu_consts.svh"

module lsu_addr_gen (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [`LSU_XLEN-1:0]     rs1,
   input  logic [`LSU_OFFSET_W-1:0] offset,
   input  lsu_pkg::lsu_size_e       size_d,
   input  logic                     atomic_d,
   output logic [`LSU_XLEN-1:0]     start_addr_dc1,
   output logic [`LSU_XLEN-1:0]     end_addr_dc1
);
   import lsu_pkg::*;

   logic [`LSU_XLEN-1:0]     rs1_dc1;
   logic [`LSU_OFFSET_W-1:0] offset_dc1;
   logic [`LSU_OFFSET_W-1:0] offset_eff_dc1;
   logic [`LSU_XLEN-1:0]     offset_sx_dc1;
   lsu_size_e                size_dc1;
   logic                     atomic_dc1;
   logic [1:0]               size_m1_dc1;

   // Operands into DC1
   always_ff @(posedge clk) begin
      rs1_dc1    <= rs1;
      offset_dc1 <= offset;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         size_dc1   <= SZ_BYTE;
         atomic_dc1 <= 1'b0;
      end else begin
         size_dc1   <= size_d;
         atomic_dc1 <= atomic_d;
      end
   end

   // Atomics address with rs1 alone
   assign offset_eff_dc1 = offset_dc1 & {`LSU_OFFSET_W{~atomic_dc1}};
   assign offset_sx_dc1  = {{(`LSU_XLEN-`LSU_OFFSET_W){offset_eff_dc1[`LSU_OFFSET_W-1]}},
                            offset_eff_dc1};

   always_comb begin
      case (size_dc1)
         SZ_HALF: size_m1_dc1 = 2'd1;
         SZ_WORD: size_m1_dc1 = 2'd3;
         default: size_m1_dc1 = 2'd0;
      endcase
   end

   assign start_addr_dc1 = rs1_dc1 + offset_sx_dc1;
   assign end_addr_dc1   = start_addr_dc1 + {{(`LSU_XLEN-2){1'b0}}, size_m1_dc1};

endmodule

`default_nettype wire

/* hdl/lsu_addr_check.sv */
`default_nettype none

`include "lsu_consts.svh"

module lsu_addr_check (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   valid_dc1,
   input  lsu_pkg::lsu_size_e     size_dc1,
   input  logic [`LSU_XLEN-1:0]   start_addr_dc1,
   input  logic [`LSU_XLEN-1:0]   end_addr_dc1,
   output lsu_pkg::lsu_region_t   region_dc1,
   output logic                   access_fault_dc2,
   output logic                   misaligned_fault_dc2,
   output lsu_pkg::lsu_mscause_e  mscause_dc2
);
   import lsu_pkg::*;

   lsu_region_t  end_region_dc1;
   logic         unaligned_dc1;
   logic         region_cross_dc1;
   logic         pic_size_dc1;
   logic         misaligned_dc1;
   logic         access_dc1;
   lsu_mscause_e mscause_dc1;

   function automatic lsu_region_t decode_region(input logic [`LSU_XLEN-1:0] addr);
      lsu_region_t r;
      r.in_dccm  = ((addr & ~(`LSU_DCCM_SIZE - 1)) == `LSU_DCCM_BASE);
      r.in_pic   = ((addr & ~(`LSU_PIC_SIZE - 1)) == `LSU_PIC_BASE);
      r.external = ~(r.in_dccm | r.in_pic);
      return r;
   endfunction

   assign region_dc1     = decode_region(start_addr_dc1);
   assign end_region_dc1 = decode_region(end_addr_dc1);

   // **************************************************
   // Fault rules, misaligned first
   // **************************************************
   assign unaligned_dc1 = ((size_dc1 == SZ_HALF) & start_addr_dc1[0]) |
                          ((size_dc1 == SZ_WORD) & (|start_addr_dc1[1:0]));

   assign misaligned_dc1   = unaligned_dc1 & ~region_dc1.in_dccm;   // DCCM takes unaligned
   assign region_cross_dc1 = (region_dc1 != end_region_dc1);
   assign pic_size_dc1     = region_dc1.in_pic & (size_dc1 != SZ_WORD);
   assign access_dc1       = ~misaligned_dc1 & (region_cross_dc1 | pic_size_dc1);

   always_comb begin
      if (misaligned_dc1)
         mscause_dc1 = MSC_MISALIGN;
      else if (region_cross_dc1)
         mscause_dc1 = MSC_REGION_CROSS;
      else if (pic_size_dc1)
         mscause_dc1 = MSC_PIC_SIZE;
      else
         mscause_dc1 = MSC_NONE;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         access_fault_dc2     <= 1'b0;
         misaligned_fault_dc2 <= 1'b0;
         mscause_dc2          <= MSC_NONE;
      end else begin
         access_fault_dc2     <= valid_dc1 & access_dc1;
         misaligned_fault_dc2 <= valid_dc1 & misaligned_dc1;
         mscause_dc2          <= valid_dc1 ? mscause_dc1 : MSC_NONE;
      end
   end

   a_region_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      valid_dc1 |-> $onehot(region_dc1));

endmodule

`default_nettype wire

/* hdl/lsu_stage_pipe.sv */
`default_nettype none

`include "lsu_consts.svh"

module lsu_stage_pipe (
   input  logic                        clk,
   input  logic                        rst_n,
   input  lsu_pkg::lsu_pkt_t           lsu_p,
   input  logic [`LSU_XLEN-1:0]        rs2,
   input  logic [`LSU_XLEN-1:0]        start_addr_dc1,
   input  logic [`LSU_XLEN-1:0]        end_addr_dc1,
   input  lsu_pkg::lsu_region_t        region_dc1,
   input  logic                        access_fault_dc2,
   input  logic                        misaligned_fault_dc2,
   input  lsu_pkg::lsu_mscause_e       mscause_dc2,
   input  logic [`LSU_NUM_THREADS-1:0] flush_dc2_up,
   input  logic [`LSU_NUM_THREADS-1:0] flush_dc3,
   input  logic [`LSU_NUM_THREADS-1:0] flush_dc4,
   input  logic [`LSU_NUM_THREADS-1:0] flush_dc5,
   output lsu_pkg::lsu_pkt_t           pkt_dc1,
   output lsu_pkg::lsu_pkt_t           pkt_dc3,
   output lsu_pkg::lsu_pkt_t           pkt_dc5,
   output logic [`LSU_XLEN-1:0]        addr_dc3,
   output logic [`LSU_XLEN-1:0]        end_addr_dc3,
   output logic [`LSU_XLEN-1:0]        addr_dc5,
   output logic [`LSU_XLEN-1:0]        end_addr_dc5,
   output logic [`LSU_XLEN-1:0]        store_data_dc3,
   output lsu_pkg::lsu_region_t        region_dc3,
   output logic                        access_fault_dc3,
   output logic                        misaligned_fault_dc3,
   output lsu_pkg::lsu_mscause_e       mscause_dc3,
   output logic                        commit_dc5
);
   import lsu_pkg::*;

   lsu_pkt_t                    pkt_in [1:5];
   lsu_pkt_t                    pkt_q  [1:5];
   logic [`LSU_NUM_THREADS-1:0] kill   [1:5];   // Flush seen entering each stage
   logic [`LSU_XLEN-1:0]        addr_q [2:5];
   logic [`LSU_XLEN-1:0]        end_q  [2:5];
   logic [`LSU_XLEN-1:0]        store_q [1:3];
   lsu_region_t                 region_dc2;

   // **************************************************
   // Packet valids with per-thread flush
   // **************************************************
   always_comb begin
      kill[1] = flush_dc2_up;
      kill[2] = flush_dc2_up;
      kill[3] = flush_dc2_up;
      kill[4] = flush_dc3;
      kill[5] = flush_dc4;
      pkt_in[1] = lsu_p;
      for (int s = 2; s <= 5; s++) begin
         pkt_in[s] = pkt_q[s-1];
      end
      for (int s = 1; s <= 5; s++) begin
         pkt_in[s].valid = pkt_in[s].valid & ~kill[s][pkt_in[s].tid];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int s = 1; s <= 5; s++) begin
            pkt_q[s] <= '0;
         end
         region_dc2           <= '0;
         region_dc3           <= '0;
         access_fault_dc3     <= 1'b0;
         misaligned_fault_dc3 <= 1'b0;
         mscause_dc3          <= MSC_NONE;
      end else begin
         for (int s = 1; s <= 5; s++) begin
            pkt_q[s] <= pkt_in[s];
         end
         region_dc2           <= region_dc1;
         region_dc3           <= region_dc2;
         access_fault_dc3     <= access_fault_dc2;
         misaligned_fault_dc3 <= misaligned_fault_dc2;
         mscause_dc3          <= mscause_dc2;
      end
   end

   // Addresses and store data ride along
   always_ff @(posedge clk) begin
      store_q[1] <= rs2;
      store_q[2] <= store_q[1];
      store_q[3] <= store_q[2];
      addr_q[2]  <= start_addr_dc1;
      end_q[2]   <= end_addr_dc1;
      for (int s = 3; s <= 5; s++) begin
         addr_q[s] <= addr_q[s-1];
         end_q[s]  <= end_q[s-1];
      end
   end

   assign pkt_dc1        = pkt_q[1];
   assign pkt_dc3        = pkt_q[3];
   assign pkt_dc5        = pkt_q[5];
   assign addr_dc3       = addr_q[3];
   assign end_addr_dc3   = end_q[3];
   assign addr_dc5       = addr_q[5];
   assign end_addr_dc5   = end_q[5];
   assign store_data_dc3 = store_q[3];

   assign commit_dc5 = pkt_q[5].valid & (pkt_q[5].load | pkt_q[5].store | pkt_q[5].atomic) &
                       ~flush_dc5[pkt_q[5].tid];

   for (genvar s = 1; s <= 5; s++) begin : g_ldst_chk
      a_not_ld_and_st: assert property (@(posedge clk) disable iff (!rst_n)
         pkt_q[s].valid |-> !(pkt_q[s].load && pkt_q[s].store));
   end

endmodule

`default_nettype wire

/* hdl/lsu_load_align.sv */
`default_nettype none

`include "lsu_consts.svh"

module lsu_load_align (
   input  logic                        clk,
   input  logic                        rst_n,
   input  lsu_pkg::lsu_pkt_t           pkt_dc3,
   input  lsu_pkg::lsu_region_t        region_dc3,
   input  logic [`LSU_XLEN-1:0]        addr_dc3,
   input  logic [`LSU_XLEN-1:0]        dccm_rdata,
   input  logic [`LSU_XLEN-1:0]        pic_rdata,
   input  logic [`LSU_XLEN-1:0]        bus_rdata,
   input  logic                        access_fault_dc3,
   input  logic                        misaligned_fault_dc3,
   input  lsu_pkg::lsu_mscause_e       mscause_dc3,
   input  logic [`LSU_NUM_THREADS-1:0] flush_dc3,
   output logic [`LSU_XLEN-1:0]        result_dc3,
   output lsu_pkg::lsu_error_pkt_t     error_pkt_dc3
);
   import lsu_pkg::*;

   logic [`LSU_XLEN-1:0] ld_data_dc3;
   logic [`LSU_XLEN-1:0] ld_ext_dc3;
   logic                 load_vld_dc3;
   logic                 exc_valid_dc3;

   // Region select by the one-hot region
   assign ld_data_dc3 = ({`LSU_XLEN{region_dc3.in_dccm}}  & dccm_rdata) |
                        ({`LSU_XLEN{region_dc3.in_pic}}   & pic_rdata)  |
                        ({`LSU_XLEN{region_dc3.external}} & bus_rdata);

   always_comb begin
      case (pkt_dc3.size)
         SZ_BYTE: ld_ext_dc3 = {{(`LSU_XLEN-8){~pkt_dc3.unsign & ld_data_dc3[7]}},
                                ld_data_dc3[7:0]};
         SZ_HALF: ld_ext_dc3 = {{(`LSU_XLEN-16){~pkt_dc3.unsign & ld_data_dc3[15]}},
                                ld_data_dc3[15:0]};
         default: ld_ext_dc3 = ld_data_dc3;
      endcase
   end

   assign load_vld_dc3 = pkt_dc3.valid & pkt_dc3.load;
   assign result_dc3   = load_vld_dc3 ? ld_ext_dc3 : '0;

   // **************************************************
   // Exception packet
   // **************************************************
   assign exc_valid_dc3 = (access_fault_dc3 | misaligned_fault_dc3) & pkt_dc3.valid &
                          ~flush_dc3[pkt_dc3.tid];

   assign error_pkt_dc3.exc_valid = exc_valid_dc3;
   assign error_pkt_dc3.inst_type = pkt_dc3.store;   // Atomics count as store when flagged
   assign error_pkt_dc3.exc_type  = ~misaligned_fault_dc3;
   assign error_pkt_dc3.mscause   = exc_valid_dc3 ? mscause_dc3 : MSC_NONE;
   assign error_pkt_dc3.addr      = addr_dc3 & {`LSU_XLEN{exc_valid_dc3}};

endmodule

`default_nettype wire

/* hdl/lsu_reservation.sv */
`default_nettype none

`include "lsu_consts.svh"

module lsu_reservation (
   input  logic                        clk,
   input  logic                        rst_n,
   input  lsu_pkg::lsu_pkt_t           pkt_dc5,
   input  logic [`LSU_XLEN-1:0]        addr_dc5,
   input  logic [`LSU_XLEN-1:0]        end_addr_dc5,
   input  logic                        commit_dc5,
   input  logic [`LSU_NUM_THREADS-1:0] lr_reset_wb,
   output logic                        sc_success_dc5,
   output logic [`LSU_NUM_THREADS-1:0] lr_vld
);
   import lsu_pkg::*;

   lsu_resv_t                   lr_tbl [`LSU_NUM_THREADS];   // One station per thread
   logic [`LSU_NUM_THREADS-1:0] lr_set;
   logic [`LSU_NUM_THREADS-1:0] lr_clr;
   logic                        own_thread;
   logic                        word_hit;

   assign sc_success_dc5 = pkt_dc5.valid & pkt_dc5.sc & lr_tbl[pkt_dc5.tid].vld &
                           (addr_dc5[`LSU_XLEN-1:2] == lr_tbl[pkt_dc5.tid].addr);

   // **************************************************
   // Set and clear per thread
   // **************************************************
   always_comb begin
      for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
         own_thread = (pkt_dc5.tid == `LSU_TID_W'(i));
         word_hit   = (addr_dc5[`LSU_XLEN-1:2] == lr_tbl[i].addr) |
                      (end_addr_dc5[`LSU_XLEN-1:2] == lr_tbl[i].addr);
         lr_set[i]  = own_thread & commit_dc5 & pkt_dc5.lr;
         // Same thread SC, match or not
         lr_clr[i]  = (own_thread & commit_dc5 & pkt_dc5.sc) |
                      (~own_thread & commit_dc5 & pkt_dc5.store &
                       (~pkt_dc5.sc | sc_success_dc5) & word_hit) |   // Failed SC writes nothing
                      lr_reset_wb[i];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
            lr_tbl[i] <= '0;
         end
      end else begin
         for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
            if (lr_clr[i]) begin
               lr_tbl[i].vld <= 1'b0;   // Clear wins over set
            end else if (lr_set[i]) begin
               lr_tbl[i].vld  <= 1'b1;
               lr_tbl[i].addr <= addr_dc5[`LSU_XLEN-1:2];
            end
         end
      end
   end

   for (genvar i = 0; i < `LSU_NUM_THREADS; i++) begin : g_vld
      assign lr_vld[i] = lr_tbl[i].vld;

      a_lr_known: assert property (@(posedge clk) disable iff (!rst_n)
         (lr_set[i] && lr_clr[i]) |=> !$isunknown(lr_vld[i]) && !lr_vld[i]);
   end

endmodule

`default_nettype wire

/* hdl/lsu_ctl_top.sv */
`default_nettype none

`include "lsu_consts.svh"

module lsu_ctl_top (
   input  logic                        clk,
   input  logic                        rst_n,
   input  lsu_pkg::lsu_pkt_t           lsu_p,
   input  logic [`LSU_XLEN-1:0]        rs1,
   input  logic [`LSU_OFFSET_W-1:0]    offset,
   input  logic [`LSU_XLEN-1:0]        rs2,
   input  logic [`LSU_NUM_THREADS-1:0] flush_dc2_up,
   input  logic [`LSU_NUM_THREADS-1:0] flush_dc3,
   input  logic [`LSU_NUM_THREADS-1:0] flush_dc4,
   input  logic [`LSU_NUM_THREADS-1:0] flush_dc5,
   input  logic [`LSU_NUM_THREADS-1:0] lr_reset_wb,
   input  logic [`LSU_XLEN-1:0]        dccm_rdata,
   input  logic [`LSU_XLEN-1:0]        pic_rdata,
   input  logic [`LSU_XLEN-1:0]        bus_rdata,
   output logic [`LSU_XLEN-1:0]        addr_dc3,
   output logic [`LSU_XLEN-1:0]        end_addr_dc3,
   output logic [`LSU_XLEN-1:0]        store_data_dc3,
   output logic [`LSU_XLEN-1:0]        result_dc3,
   output lsu_pkg::lsu_region_t        region_dc3,
   output lsu_pkg::lsu_error_pkt_t     error_pkt_dc3,
   output logic                        commit_dc5,
   output logic                        sc_success_dc5,
   output logic [`LSU_NUM_THREADS-1:0] lr_vld
);

   logic [`LSU_XLEN-1:0]  start_addr_dc1;
   logic [`LSU_XLEN-1:0]  end_addr_dc1;
   lsu_pkg::lsu_region_t  region_dc1;
   lsu_pkg::lsu_pkt_t     pkt_dc1;
   lsu_pkg::lsu_pkt_t     pkt_dc3;
   lsu_pkg::lsu_pkt_t     pkt_dc5;
   logic                  access_fault_dc2;
   logic                  misaligned_fault_dc2;
   lsu_pkg::lsu_mscause_e mscause_dc2;
   logic                  access_fault_dc3;
   logic                  misaligned_fault_dc3;
   lsu_pkg::lsu_mscause_e mscause_dc3;
   logic [`LSU_XLEN-1:0]  addr_dc5;
   logic [`LSU_XLEN-1:0]  end_addr_dc5;

   // Size and atomic go straight from the D-stage packet
   lsu_addr_gen addr_gen_i (
      .clk, .rst_n, .rs1, .offset,
      .size_d         (lsu_p.size),
      .atomic_d       (lsu_p.atomic),
      .start_addr_dc1,
      .end_addr_dc1
   );

   lsu_addr_check addr_check_i (
      .clk, .rst_n,
      .valid_dc1      (pkt_dc1.valid),
      .size_dc1       (pkt_dc1.size),
      .start_addr_dc1, .end_addr_dc1, .region_dc1,
      .access_fault_dc2, .misaligned_fault_dc2, .mscause_dc2
   );

   lsu_stage_pipe stage_pipe_i (
      .clk, .rst_n, .lsu_p, .rs2,
      .start_addr_dc1, .end_addr_dc1, .region_dc1,
      .access_fault_dc2, .misaligned_fault_dc2, .mscause_dc2,
      .flush_dc2_up, .flush_dc3, .flush_dc4, .flush_dc5,
      .pkt_dc1, .pkt_dc3, .pkt_dc5,
      .addr_dc3, .end_addr_dc3, .addr_dc5, .end_addr_dc5, .store_data_dc3,
      .region_dc3, .access_fault_dc3, .misaligned_fault_dc3, .mscause_dc3,
      .commit_dc5
   );

   lsu_load_align load_align_i (
      .clk, .rst_n, .pkt_dc3, .region_dc3, .addr_dc3,
      .dccm_rdata, .pic_rdata, .bus_rdata,
      .access_fault_dc3, .misaligned_fault_dc3, .mscause_dc3,
      .flush_dc3, .result_dc3, .error_pkt_dc3
   );

   lsu_reservation reservation_i (
      .clk, .rst_n, .pkt_dc5, .addr_dc5, .end_addr_dc5,
      .commit_dc5, .lr_reset_wb, .sc_success_dc5, .lr_vld
   );

endmodule

`default_nettype wire

/* verif/lsu_ctl_tb.sv */
`default_nettype none

`include "lsu_consts.svh"

module lsu_ctl_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import lsu_pkg::*;

   localparam int NUM_TESTS = 5;
   localparam int RESET_CYC = 10;
   localparam int WDOG_CYC  = NUM_TESTS * 40 + RESET_CYC;

   localparam logic [31:0] EXT_BASE = 32'h2000_0000;   // Outside both windows

   logic           clk = 1'b0;
   logic           rst_n;
   lsu_pkt_t       lsu_p;
   logic [31:0]    rs1;
   logic [11:0]    offset;
   logic [31:0]    rs2;
   logic [1:0]     flush_dc2_up;
   logic [1:0]     flush_dc3;
   logic [1:0]     flush_dc4;
   logic [1:0]     flush_dc5;
   logic [1:0]     lr_reset_wb;
   logic [31:0]    dccm_rdata;
   logic [31:0]    pic_rdata;
   logic [31:0]    bus_rdata;
   logic [31:0]    addr_dc3;
   logic [31:0]    end_addr_dc3;
   logic [31:0]    store_data_dc3;
   logic [31:0]    result_dc3;
   lsu_region_t    region_dc3;
   lsu_error_pkt_t error_pkt_dc3;
   logic           commit_dc5;
   logic           sc_success_dc5;
   logic [1:0]     lr_vld;

   integer seed = 48583;
   int     errors = 0;
   int     tests_run = 0;
   int     tests_failed = 0;

   always #2 clk = ~clk;

   lsu_ctl_top dut_i (.*);

   // **************************************************
   // Helpers
   // **************************************************
   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic tick();   // Drive point 1 ns after the rising edge
      @(posedge clk);
      #1;
   endtask

   task automatic idle_inputs();
      lsu_p        = '0;
      rs1          = '0;
      offset       = '0;
      rs2          = '0;
      flush_dc2_up = '0;
      flush_dc3    = '0;
      flush_dc4    = '0;
      flush_dc5    = '0;
      lr_reset_wb  = '0;
   endtask

   task automatic finish_test(input string name, input int start_err);
      tests_run++;
      if (errors == start_err) begin
         $display("test %-20s ok", name);
      end else begin
         tests_failed++;
         $display("test %-20s %0d mismatches", name, errors - start_err);
      end
   endtask

   function automatic lsu_pkt_t make_pkt(input logic tid, input logic ld, input logic st,
                                         input logic uns, input lsu_size_e sz,
                                         input logic amo, input logic lr, input logic sc);
      lsu_pkt_t p;
      p        = '0;
      p.valid  = 1'b1;
      p.tid    = tid;
      p.load   = ld;
      p.store  = st;
      p.unsign = uns;
      p.size   = sz;
      p.atomic = amo;
      p.lr     = lr;
      p.sc     = sc;
      return p;
   endfunction

   function automatic logic [31:0] size_bytes(input lsu_size_e sz);
      case (sz)
         SZ_HALF: return 32'd2;
         SZ_WORD: return 32'd4;
         default: return 32'd1;
      endcase
   endfunction

   // Expected region from the memory map ranges
   function automatic lsu_region_t region_of(input logic [31:0] a);
      lsu_region_t r;
      r = '0;
      if (a >= `LSU_DCCM_BASE && a < `LSU_DCCM_BASE + `LSU_DCCM_SIZE) begin
         r.in_dccm = 1'b1;
      end else if (a >= `LSU_PIC_BASE && a < `LSU_PIC_BASE + `LSU_PIC_SIZE) begin
         r.in_pic = 1'b1;
      end else begin
         r.external = 1'b1;
      end
      return r;
   endfunction

   function automatic logic [31:0] load_value(input logic [31:0] raw, input lsu_size_e sz,
                                              input logic uns);
      logic [31:0] v;
      case (sz)
         SZ_BYTE: v = uns ? {24'h0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
         SZ_HALF: v = uns ? {16'h0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
         default: v = raw;
      endcase
      return v;
   endfunction

   // Packet sampled at the next edge then lsu_p idles
   task automatic issue(input lsu_pkt_t p, input logic [31:0] a, input logic [11:0] off,
                        input logic [31:0] d);
      lsu_p  = p;
      rs1    = a;
      offset = off;
      rs2    = d;
      tick();
      lsu_p  = '0;
   endtask

   task automatic run_dc3(input lsu_pkt_t p, input logic [31:0] a, input logic [11:0] off,
                          input logic [31:0] d);
      issue(p, a, off, d);
      tick();
      tick();
      @(negedge clk);   // DC3 outputs settled
   endtask

   // **************************************************
   // Directed tests
   // **************************************************
   task automatic test_addr_gen();
      lsu_size_e   sz;
      logic [31:0] base;
      logic [11:0] off;
      logic [31:0] data;
      logic [31:0] exp_addr;
      int          start_err;
      start_err = errors;
      for (int i = 0; i < 3; i++) begin
         sz = lsu_size_e'(i[1:0]);
         for (int j = 0; j < 3; j++) begin
            base     = $random(seed);
            off      = 12'($random(seed));
            data     = $random(seed);
            exp_addr = base + {{20{off[11]}}, off};
            run_dc3(make_pkt(1'b0, 1'b0, 1'b1, 1'b0, sz, 1'b0, 1'b0, 1'b0), base, off, data);
            check("addr_dc3", addr_dc3, exp_addr);
            check("end_addr_dc3", end_addr_dc3, exp_addr + size_bytes(sz) - 32'd1);
            check("store_data_dc3", store_data_dc3, data);
            tick();
         end
      end
      finish_test("address generation", start_err);
   endtask

   task automatic test_load_format();
      logic [31:0] addr_list [3];
      logic [31:0] data_list [3];
      lsu_size_e   sz;
      logic        uns;
      int          start_err;
      start_err    = errors;
      addr_list[0] = `LSU_DCCM_BASE + 32'h100;
      addr_list[1] = `LSU_PIC_BASE + 32'h20;
      addr_list[2] = EXT_BASE + 32'h40;
      data_list[0] = 32'h1234_F3E1;   // Negative byte and half
      data_list[1] = 32'h5678_80A5;
      data_list[2] = 32'h9ABC_7F96;   // Positive half, negative byte
      dccm_rdata   = data_list[0];
      pic_rdata    = data_list[1];
      bus_rdata    = data_list[2];
      for (int r = 0; r < 3; r++) begin
         for (int v = 0; v < 5; v++) begin
            sz  = lsu_size_e'(2'(v / 2));
            uns = v[0];
            run_dc3(make_pkt(1'b1, 1'b1, 1'b0, uns, sz, 1'b0, 1'b0, 1'b0),
                    addr_list[r], 12'h0, 32'h0);
            check($sformatf("region_dc3 r%0d", r), 32'(region_dc3),
                  32'(region_of(addr_list[r])));
            check($sformatf("result_dc3 r%0d v%0d", r, v), result_dc3,
                  load_value(data_list[r], sz, uns));
            tick();
         end
      end
      finish_test("load formatting", start_err);
   endtask

   task automatic fault_case(input string name, input lsu_pkt_t p, input logic [31:0] a,
                             input logic exp_vld, input logic exp_acc,
                             input lsu_mscause_e exp_cause);
      run_dc3(p, a, 12'h0, 32'h0);
      check({name, " exc_valid"}, 32'(error_pkt_dc3.exc_valid), 32'(exp_vld));
      if (exp_vld) begin
         check({name, " exc_type"}, 32'(error_pkt_dc3.exc_type), 32'(exp_acc));
         check({name, " inst_type"}, 32'(error_pkt_dc3.inst_type), 32'(p.store));
      end
      check({name, " mscause"}, 32'(error_pkt_dc3.mscause), 32'(exp_cause));
      check({name, " addr"}, error_pkt_dc3.addr, exp_vld ? a : 32'h0);
      tick();
   endtask

   task automatic test_faults();
      int start_err;
      start_err = errors;
      fault_case("ext unaligned word", make_pkt(1'b0, 1'b1, 1'b0, 1'b0, SZ_WORD, 1'b0,
                 1'b0, 1'b0), EXT_BASE + 32'h2, 1'b1, 1'b0, MSC_MISALIGN);
      // Word straddles the top of the DCCM window
      fault_case("dccm region cross", make_pkt(1'b0, 1'b1, 1'b0, 1'b0, SZ_WORD, 1'b0,
                 1'b0, 1'b0), `LSU_DCCM_BASE + `LSU_DCCM_SIZE - 32'd2, 1'b1, 1'b1,
                 MSC_REGION_CROSS);
      fault_case("pic half store", make_pkt(1'b1, 1'b0, 1'b1, 1'b0, SZ_HALF, 1'b0,
                 1'b0, 1'b0), `LSU_PIC_BASE + 32'h4, 1'b1, 1'b1, MSC_PIC_SIZE);
      fault_case("dccm aligned load", make_pkt(1'b0, 1'b1, 1'b0, 1'b0, SZ_WORD, 1'b0,
                 1'b0, 1'b0), `LSU_DCCM_BASE + 32'h8, 1'b0, 1'b0, MSC_NONE);
      finish_test("faults", start_err);
   endtask

   // Slot k drives the cycle before edge E+k
   // Stores A..D issue in slots 0..3
   task automatic test_flush();
      lsu_pkt_t st_pkt [4];
      logic     exp_commit;
      int       start_err;
      start_err = errors;
      for (int k = 0; k < 4; k++) begin
         st_pkt[k] = make_pkt(k[0], 1'b0, 1'b1, 1'b0, SZ_WORD, 1'b0, 1'b0, 1'b0);
      end
      repeat (5) tick();   // Empty the five stages
      for (int k = 0; k <= 10; k++) begin
         if (k < 4) begin
            lsu_p = st_pkt[k];
         end else begin
            lsu_p = '0;
         end
         rs1        = EXT_BASE + 32'(k * 4);
         flush_dc3  = (k == 4) ? 2'b10 : 2'b00;   // B of thread 1 in DC3
         flush_dc5  = (k == 7) ? 2'b01 : 2'b00;   // C of thread 0 in DC5
         exp_commit = (k == 5) || (k == 8);
         @(negedge clk);
         check($sformatf("commit_dc5 slot %0d", k), 32'(commit_dc5), 32'(exp_commit));
         tick();
      end
      idle_inputs();
      finish_test("flush", start_err);
   endtask

   task automatic lrsc_op(input string name, input lsu_pkt_t p, input logic [31:0] a,
                          input logic [11:0] off, input logic exp_sc,
                          input logic [1:0] exp_vld);
      issue(p, a, off, 32'hC0DE_0000);
      repeat (4) tick();
      @(negedge clk);   // Packet in DC5
      check({name, " commit_dc5"}, 32'(commit_dc5), 32'd1);
      check({name, " sc_success_dc5"}, 32'(sc_success_dc5), 32'(exp_sc));
      tick();           // Reservation updated at edge 5
      check({name, " lr_vld"}, 32'(lr_vld), 32'(exp_vld));
   endtask

   task automatic test_lrsc();
      lsu_pkt_t    lr_pkt;
      lsu_pkt_t    sc_pkt;
      lsu_pkt_t    st_pkt;
      logic [31:0] w;
      int          start_err;
      start_err = errors;
      w         = `LSU_DCCM_BASE + 32'h40;
      lr_pkt    = make_pkt(1'b0, 1'b1, 1'b0, 1'b0, SZ_WORD, 1'b1, 1'b1, 1'b0);
      sc_pkt    = make_pkt(1'b0, 1'b0, 1'b1, 1'b0, SZ_WORD, 1'b1, 1'b0, 1'b1);
      st_pkt    = make_pkt(1'b1, 1'b0, 1'b1, 1'b0, SZ_WORD, 1'b0, 1'b0, 1'b0);
      lrsc_op("lr t0", lr_pkt, w, 12'h0, 1'b0, 2'b01);
      lrsc_op("sc t0", sc_pkt, w, 12'h10, 1'b1, 2'b00);   // Atomic ignores the offset
      lrsc_op("lr t0 again", lr_pkt, w, 12'h0, 1'b0, 2'b01);
      lrsc_op("store t1", st_pkt, w - 32'd8, 12'h8, 1'b0, 2'b00);
      lrsc_op("sc t0 late", sc_pkt, w, 12'h0, 1'b0, 2'b00);
      lrsc_op("lr t0 third", lr_pkt, w, 12'h0, 1'b0, 2'b01);
      lr_reset_wb = 2'b01;
      tick();
      check("lr_vld after lr_reset_wb", 32'(lr_vld), 32'd0);
      lr_reset_wb = 2'b00;
      finish_test("lr/sc", start_err);
   endtask

   initial begin
      idle_inputs();
      dccm_rdata = '0;
      pic_rdata  = '0;
      bus_rdata  = '0;
      rst_n      = 1'b0;
      repeat (RESET_CYC) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      check("commit_dc5 after reset", 32'(commit_dc5), 32'd0);
      check("exc_valid after reset", 32'(error_pkt_dc3.exc_valid), 32'd0);
      check("lr_vld after reset", 32'(lr_vld), 32'd0);
      tick();

      test_addr_gen();
      test_load_format();
      test_faults();
      test_flush();
      test_lrsc();

      $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // Watchdog sized from the test count
   initial begin
      repeat (WDOG_CYC) @(posedge clk);
      $display("ERROR: watchdog expired after %0d cycles, tests did not finish", WDOG_CYC);
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
hdl/lsu_pkg.sv
hdl/lsu_addr_gen.sv
hdl/lsu_addr_check.sv
hdl/lsu_stage_pipe.sv
hdl/lsu_load_align.sv
hdl/lsu_reservation.sv
hdl/lsu_ctl_top.sv
verif/lsu_ctl_tb.sv

/* Makefile */
# Verilator build and run of the LSU control path testbench

VERILATOR ?= verilator
TOP       ?= lsu_ctl_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
